/* anim_consts.svh */
`ifndef ANIM_CONSTS_SVH
`define ANIM_CONSTS_SVH

// frame geometry, 128 x 128 one-bit pixels
`define FRAME_X_BITS    7
`define FRAME_Y_BITS    7
`define PIX_ADDR_BITS   (`FRAME_X_BITS + `FRAME_Y_BITS)

// animation length
`define FRAME_COUNT     4
`define FRAME_IDX_BITS  2

// complete scans each frame stays on screen
`define HOLD_SCANS      2

`endif

/* anim_pkg.sv */
`default_nettype none

`include "anim_consts.svh"

package anim_pkg;

   // row in the upper bits, column in the lower bits
   typedef logic [`PIX_ADDR_BITS-1:0] pix_addr_t;

   // which of the frame memories is meant
   typedef logic [`FRAME_IDX_BITS-1:0] frame_idx_t;

endpackage

`default_nettype wire

/* frame_store.sv */
`default_nettype none

`include "anim_consts.svh"

module frame_store #(
   parameter int ADDR_W = `PIX_ADDR_BITS
) (
   input  wire                  clk,
   input  wire                  wr_en,
   input  anim_pkg::pix_addr_t  wr_addr,
   input  wire                  wr_bit,
   input  wire                  rd_en,
   input  anim_pkg::pix_addr_t  rd_addr,
   output logic                 rd_bit
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic mem [0:DEPTH-1];                    // one bit per pixel, loaded by the host

   // write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_bit;
      end
   end

   // read port, old data wins on a collision
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_bit <= mem[rd_addr];             // output holds while rd_en is low
      end
   end

   a_wr_addr_known : assert property (
      @(posedge clk) wr_en |-> !$isunknown(wr_addr)
   ) else $error("frame_store: write with unknown address");

endmodule

`default_nettype wire

/* frame_bank.sv */
`default_nettype none

`include "anim_consts.svh"

module frame_bank #(
   parameter int N_FRAMES = `FRAME_COUNT
) (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   load_en,
   input  anim_pkg::frame_idx_t  load_frame,
   input  anim_pkg::pix_addr_t   load_addr,
   input  wire                   load_bit,
   input  wire                   rd_valid,
   input  anim_pkg::pix_addr_t   rd_addr,
   input  anim_pkg::frame_idx_t  rd_frame,
   output logic                  pixel_val,
   output logic                  pixel_valid,
   output anim_pkg::frame_idx_t  pixel_frame
);

   logic [N_FRAMES-1:0]   wr_sel;             // one-hot write enable per frame
   logic [N_FRAMES-1:0]   rd_bits;            // read data of every memory
   anim_pkg::frame_idx_t  frame_q;            // frame of the read in flight
   logic                  valid_q;

   // host write decode
   always_comb begin
      for (int i = 0; i < N_FRAMES; i++) begin
         wr_sel[i] = load_en && (load_frame == anim_pkg::frame_idx_t'(i));
      end
   end

   // all memories read the same address, the frame picks the result
   generate
      for (genvar i = 0; i < N_FRAMES; i++) begin : g_frame
         frame_store #(
            .ADDR_W  (`PIX_ADDR_BITS)
         ) u_store (
            .clk     (clk),
            .wr_en   (wr_sel[i]),
            .wr_addr (load_addr),
            .wr_bit  (load_bit),
            .rd_en   (rd_valid),
            .rd_addr (rd_addr),
            .rd_bit  (rd_bits[i])
         );
      end
   endgenerate

   // side band that travels with the memory read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frame_q <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= rd_valid;
         if (rd_valid) begin
            frame_q <= rd_frame;              // keep the last frame over a pause
         end
      end
   end

   assign pixel_val   = rd_bits[frame_q];
   assign pixel_valid = valid_q;
   assign pixel_frame = frame_q;

   a_load_frame_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      load_en |-> (int'(load_frame) < N_FRAMES)
   ) else $error("frame_bank: load to frame %0d out of range", load_frame);

endmodule

`default_nettype wire

/* pixel_scanner.sv */
`default_nettype none

`include "anim_consts.svh"

module pixel_scanner (
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire                  enable,
   output anim_pkg::pix_addr_t  scan_addr,
   output logic                 scan_valid,
   output logic                 scan_last
);

   localparam logic [`FRAME_X_BITS-1:0] COL_MAX = '1;
   localparam logic [`FRAME_Y_BITS-1:0] ROW_MAX = '1;

   logic [`FRAME_X_BITS-1:0] col;
   logic [`FRAME_Y_BITS-1:0] row;
   logic                     col_wrap;

   assign col_wrap = (col == COL_MAX);

   // raster order, column runs fastest
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         col <= '0;
         row <= '0;
      end else if (enable) begin
         col <= col + 1'b1;                   // wraps to 0 at the line end
         if (col_wrap) begin
            row <= row + 1'b1;                // wraps to 0 after the last line
         end
      end
   end

   assign scan_addr  = {row, col};
   assign scan_valid = enable;                // address is held while paused
   assign scan_last  = enable && col_wrap && (row == ROW_MAX);

   a_raster_step : assert property (
      @(posedge clk) disable iff (!arst_n)
      scan_valid |=> (scan_addr == $past(scan_addr) + 1'b1)
   ) else $error("pixel_scanner: address did not step in raster order");

endmodule

`default_nettype wire

/* frame_sequencer.sv */
`default_nettype none

`include "anim_consts.svh"

module frame_sequencer (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   scan_valid,
   input  wire                   scan_last,
   output anim_pkg::frame_idx_t  cur_frame
);

   localparam int CNT_W = $clog2(`HOLD_SCANS + 1);

   localparam logic [CNT_W-1:0]     CNT_LAST   = CNT_W'(`HOLD_SCANS - 1);
   localparam anim_pkg::frame_idx_t FRAME_LAST = anim_pkg::frame_idx_t'(`FRAME_COUNT - 1);

   logic [CNT_W-1:0] scan_cnt;                // completed scans of the current frame
   logic             scan_end;

   assign scan_end = scan_valid && scan_last;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scan_cnt  <= '0;
         cur_frame <= '0;
      end else if (scan_end) begin
         if (scan_cnt == CNT_LAST) begin
            scan_cnt <= '0;
            // step to the next frame and wrap after the last one
            if (cur_frame == FRAME_LAST) begin
               cur_frame <= '0;
            end else begin
               cur_frame <= cur_frame + 1'b1;
            end
         end else begin
            scan_cnt <= scan_cnt + 1'b1;
         end
      end
   end

   a_frame_step : assert property (
      @(posedge clk) disable iff (!arst_n)
      $changed(cur_frame) |-> $past(scan_valid && scan_last)
   ) else $error("frame_sequencer: frame changed outside a scan end");

endmodule

`default_nettype wire

/* anim_display_top.sv */
`default_nettype none

`include "anim_consts.svh"

module anim_display_top (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   enable,
   input  wire                   load_en,
   input  anim_pkg::frame_idx_t  load_frame,
   input  anim_pkg::pix_addr_t   load_addr,
   input  wire                   load_bit,
   output logic                  pixel_val,
   output logic                  pixel_valid,
   output anim_pkg::pix_addr_t   pixel_addr,
   output anim_pkg::frame_idx_t  pixel_frame,
   output logic                  scan_done
);

   anim_pkg::pix_addr_t   scan_addr;
   logic                  scan_valid;
   logic                  scan_last;
   anim_pkg::frame_idx_t  cur_frame;

   pixel_scanner u_scanner (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .scan_addr  (scan_addr),
      .scan_valid (scan_valid),
      .scan_last  (scan_last)
   );

   frame_sequencer u_sequencer (
      .clk        (clk),
      .arst_n     (arst_n),
      .scan_valid (scan_valid),
      .scan_last  (scan_last),
      .cur_frame  (cur_frame)
   );

   frame_bank #(
      .N_FRAMES    (`FRAME_COUNT)
   ) u_bank (
      .clk         (clk),
      .arst_n      (arst_n),
      .load_en     (load_en),
      .load_frame  (load_frame),
      .load_addr   (load_addr),
      .load_bit    (load_bit),
      .rd_valid    (scan_valid),
      .rd_addr     (scan_addr),
      .rd_frame    (cur_frame),
      .pixel_val   (pixel_val),
      .pixel_valid (pixel_valid),
      .pixel_frame (pixel_frame)
   );

   // same one cycle delay as the memory read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pixel_addr <= '0;
         scan_done  <= 1'b0;
      end else begin
         if (scan_valid) begin
            pixel_addr <= scan_addr;          // last shown pixel during a pause
         end
         scan_done <= scan_valid && scan_last;
      end
   end

endmodule

`default_nettype wire

/* anim_checker.sv */
`default_nettype none

`include "anim_consts.svh"

module anim_checker (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   enable,
   input  wire                   load_en,
   input  anim_pkg::frame_idx_t  load_frame,
   input  anim_pkg::pix_addr_t   load_addr,
   input  wire                   load_bit,
   input  wire                   pixel_val,
   input  wire                   pixel_valid,
   input  anim_pkg::pix_addr_t   pixel_addr,
   input  anim_pkg::frame_idx_t  pixel_frame,
   input  wire                   scan_done,
   input  wire                   frame_chk_en,
   input  anim_pkg::frame_idx_t  frame_chk,
   output int                    err_cnt
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LAST_ADDR = (1 << `PIX_ADDR_BITS) - 1;

   bit model [0:`FRAME_COUNT-1][0:LAST_ADDR];   // host view of every frame
   int errors = 0;
   int exp_addr;
   int exp_frame;
   int scans_seen;                               // completed scans of exp_frame
   bit en_q;                                     // enable one cycle back
   bit wr_pend;
   int wr_frame;
   int wr_addr;
   bit wr_bit;

   assign err_cnt = errors;

   task automatic log_mismatch(input string msg);
      errors++;
      if (errors <= 20) begin                   // keep the log short on a broken build
         $display("error at %0d ns: %s", $time, msg);
      end
   endtask

   always @(posedge clk) begin
      if (!arst_n) begin
         if (pixel_valid || scan_done) begin
            log_mismatch("pixel_valid or scan_done high during reset");
         end
         exp_addr   = 0;
         exp_frame  = 0;
         scans_seen = 0;
         en_q       = 1'b0;
      end else begin
         if (pixel_valid !== en_q) begin
            log_mismatch($sformatf("pixel_valid %b, enable a cycle earlier %b",
                                   pixel_valid, en_q));
         end
         if (pixel_valid) begin
            if (int'(pixel_addr) != exp_addr) begin
               log_mismatch($sformatf("pixel_addr %0d, expected %0d", pixel_addr, exp_addr));
            end
            if (int'(pixel_frame) != exp_frame) begin
               log_mismatch($sformatf("pixel_frame %0d, expected %0d", pixel_frame, exp_frame));
            end
            if (pixel_val !== model[exp_frame][exp_addr]) begin
               log_mismatch($sformatf("pixel_val %b at frame %0d addr %0d, expected %b",
                                      pixel_val, exp_frame, exp_addr,
                                      model[exp_frame][exp_addr]));
            end
            if (scan_done !== (exp_addr == LAST_ADDR)) begin
               log_mismatch($sformatf("scan_done %b at addr %0d", scan_done, exp_addr));
            end
            // raster order, frame steps after HOLD_SCANS full scans
            if (exp_addr == LAST_ADDR) begin
               exp_addr = 0;
               scans_seen++;
               if (scans_seen == `HOLD_SCANS) begin
                  scans_seen = 0;
                  exp_frame  = (exp_frame + 1) % `FRAME_COUNT;
               end
            end else begin
               exp_addr++;
            end
         end else if (scan_done) begin
            log_mismatch("scan_done without pixel_valid");
         end
         if (frame_chk_en && (pixel_frame != frame_chk)) begin
            log_mismatch($sformatf("displayed frame %0d, expected %0d", pixel_frame, frame_chk));
         end
         en_q = enable;
      end
      // the bank reads before it writes, so a write shows up one edge later
      if (wr_pend) begin
         model[wr_frame][wr_addr] = wr_bit;
      end
      wr_pend  = load_en;
      wr_frame = int'(load_frame);
      wr_addr  = int'(load_addr);
      wr_bit   = load_bit;
   end

endmodule

`default_nettype wire

/* tb_anim_display.sv */
`default_nettype none

`include "anim_consts.svh"

module tb_anim_display;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int SCAN_CYCLES  = 1 << `PIX_ADDR_BITS;
   localparam int RESET_CYCLES = 16;

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic                  enable;
   logic                  load_en;
   anim_pkg::frame_idx_t  load_frame;
   anim_pkg::pix_addr_t   load_addr;
   logic                  load_bit;
   logic                  pixel_val;
   logic                  pixel_valid;
   anim_pkg::pix_addr_t   pixel_addr;
   anim_pkg::frame_idx_t  pixel_frame;
   logic                  scan_done;
   logic                  frame_chk_en;
   anim_pkg::frame_idx_t  frame_chk;
   int                    err_cnt;

   byte cmd_q[$];                                // command letter per test
   int  arg_a[$];
   int  arg_b[$];
   int  arg_c[$];
   int  budget_cycles;
   bit  budget_ready = 1'b0;
   int  pass_cnt;
   int  fail_cnt;

   always #2 clk = ~clk;                         // 4 ns period

   anim_display_top dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .enable      (enable),
      .load_en     (load_en),
      .load_frame  (load_frame),
      .load_addr   (load_addr),
      .load_bit    (load_bit),
      .pixel_val   (pixel_val),
      .pixel_valid (pixel_valid),
      .pixel_addr  (pixel_addr),
      .pixel_frame (pixel_frame),
      .scan_done   (scan_done)
   );

   anim_checker u_checker (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .load_en      (load_en),
      .load_frame   (load_frame),
      .load_addr    (load_addr),
      .load_bit     (load_bit),
      .pixel_val    (pixel_val),
      .pixel_valid  (pixel_valid),
      .pixel_addr   (pixel_addr),
      .pixel_frame  (pixel_frame),
      .scan_done    (scan_done),
      .frame_chk_en (frame_chk_en),
      .frame_chk    (frame_chk),
      .err_cnt      (err_cnt)
   );

   function automatic bit read_tests();
      int    fd;
      int    c;
      int    a1;
      int    a2;
      int    a3;
      string line;
      fd = $fopen("anim_tests.txt", "r");
      if (fd == 0) begin
         return 1'b0;
      end
      while ($fgets(line, fd) > 0) begin
         c  = 0;
         a1 = 0;
         a2 = 0;
         a3 = 0;
         void'($sscanf(line, "%c %d %d %d", c, a1, a2, a3));
         case (byte'(c))
            "L", "P", "S", "H", "R": begin
               cmd_q.push_back(byte'(c));
               arg_a.push_back(a1);
               arg_b.push_back(a2);
               arg_c.push_back(a3);
            end
            default: ;                           // comment or blank line
         endcase
      end
      $fclose(fd);
      return cmd_q.size() > 0;
   endfunction

   // cycles the tests need, a few extra per test for draining
   function automatic int count_cycles();
      int total;
      total = RESET_CYCLES;
      foreach (cmd_q[i]) begin
         case (cmd_q[i])
            "L": total += SCAN_CYCLES;
            "P": total += 1;
            "S": total += arg_a[i] * SCAN_CYCLES;
            "H": total += SCAN_CYCLES + arg_a[i];
            default: total += SCAN_CYCLES + RESET_CYCLES;
         endcase
         total += 8;
      end
      return total;
   endfunction

   task automatic apply_reset();
      @(negedge clk);
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic fill_frame(input int f);
      for (int a = 0; a < SCAN_CYCLES; a++) begin
         @(negedge clk);
         load_en    = 1'b1;
         load_frame = anim_pkg::frame_idx_t'(f);
         load_addr  = anim_pkg::pix_addr_t'(a);
         load_bit   = 1'($urandom);
      end
      @(negedge clk);
      load_en = 1'b0;
   endtask

   task automatic poke_pixel(input int f, input int a, input int b);
      @(negedge clk);
      load_en    = 1'b1;
      load_frame = anim_pkg::frame_idx_t'(f);
      load_addr  = anim_pkg::pix_addr_t'(a);
      load_bit   = 1'(b);
      @(negedge clk);
      load_en = 1'b0;
   endtask

   // one address per enabled cycle, so a scan is SCAN_CYCLES long
   task automatic run_scans(input int n, input int e);
      @(negedge clk);
      enable = 1'b1;
      repeat (n * SCAN_CYCLES) @(negedge clk);
      enable = 1'b0;
      @(negedge clk);
      frame_chk_en = 1'b1;                       // checker compares pixel_frame
      frame_chk    = anim_pkg::frame_idx_t'(e);
      @(negedge clk);
      frame_chk_en = 1'b0;
   endtask

   task automatic hold_mid_scan(input int c);
      int pos;
      pos = 1 + int'($urandom % (SCAN_CYCLES - 1));
      @(negedge clk);
      enable = 1'b1;
      repeat (pos) @(negedge clk);
      enable = 1'b0;
      repeat (c) @(negedge clk);
      enable = 1'b1;
      repeat (SCAN_CYCLES - pos) @(negedge clk);
      enable = 1'b0;
   endtask

   // reset hits a scan that is still running
   task automatic reset_mid_scan();
      int pos;
      pos = 1 + int'($urandom % (SCAN_CYCLES - 1));
      @(negedge clk);
      enable = 1'b1;
      repeat (pos) @(negedge clk);
      enable = 1'b0;
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
   endtask

   initial begin
      int errs_before;
      arst_n       = 1'b0;
      enable       = 1'b0;
      load_en      = 1'b0;
      load_frame   = '0;
      load_addr    = '0;
      load_bit     = 1'b0;
      frame_chk_en = 1'b0;
      frame_chk    = '0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      void'($urandom(48));
      if (!read_tests()) begin
         $display("no tests could be read from anim_tests.txt");
         $display("TB FAILED");
         $finish;
      end else begin
         budget_cycles = count_cycles() * 2 + 2000;
         budget_ready  = 1'b1;
         apply_reset();
         foreach (cmd_q[i]) begin
            errs_before = err_cnt;
            case (cmd_q[i])
               "L": fill_frame(arg_a[i]);
               "P": poke_pixel(arg_a[i], arg_b[i], arg_c[i]);
               "S": run_scans(arg_a[i], arg_b[i]);
               "H": hold_mid_scan(arg_a[i]);
               default: reset_mid_scan();
            endcase
            repeat (3) @(negedge clk);            // last pixel reaches the checker
            if (err_cnt == errs_before) begin
               pass_cnt++;
               $display("test %0d  %c %0d %0d %0d  ok", i + 1, cmd_q[i],
                        arg_a[i], arg_b[i], arg_c[i]);
            end else begin
               fail_cnt++;
               $display("test %0d  %c %0d %0d %0d  failed", i + 1, cmd_q[i],
                        arg_a[i], arg_b[i], arg_c[i]);
            end
         end
         $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
         if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
         $finish;
      end
   end

   // watchdog
   initial begin
      wait (budget_ready);
      repeat (budget_cycles) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles", budget_cycles);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* anim_tests.txt */
# L frame | P frame addr bit | S scans expected_frame | H hold_cycles | R
# numbers are decimal, frames 0 to 3, addresses 0 to 16383
L 0
L 1
L 2
L 3
S 1 0
S 1 0
S 2 1
H 40
S 1 2
H 3
S 3 0
P 1 100 1
P 1 8191 0
S 2 1
S 2 2
R
S 1 0
P 0 16383 1
S 1 0
S 2 1
H 1
S 5 0
R
H 10
S 1 0

/* tb.f */
+incdir+.
anim_pkg.sv
frame_store.sv
frame_bank.sv
pixel_scanner.sv
frame_sequencer.sv
anim_display_top.sv
anim_checker.sv
tb_anim_display.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_anim_display
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/Vtb_anim_display)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi
